/* rvCore.f */
+incdir+hdl
hdl/rvCorePkg.sv
hdl/coreControl.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/execUnit.sv
hdl/rvCore.sv
tb/rvCoreTb.sv

/* Bender.yml */
package:
  name: rvCore

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/rvCorePkg.sv
      - hdl/coreControl.sv
      - hdl/instrDecoder.sv
      - hdl/regFile.sv
      - hdl/execUnit.sv
      - hdl/rvCore.sv
  - target: test
    files:
      - tb/rvCoreTb.sv

/* tb/rvCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_macros.svh"

module rvCoreTb;

   import rvCorePkg::*;

   localparam int memWords = 256;
   localparam int dataBase = 128;   // Program below and data from here up
   localparam int maxProg  = 64;
   localparam int numTests = 8;

   typedef struct packed {
      word_t addr;
      word_t data;
   } storeRec_t;

   logic    clk;
   logic    rstn;
   logic    start;
   logic    ack;
   word_t   rdata;
   logic    req;
   logic    halted;
   memReq_t memReq;

   word_t       mem [memWords];
   word_t       expMem [memWords];
   storeRec_t   expLog [$];
   int          storeIdx;
   int          haltPc;
   int          progLen;
   int          testErrors;
   int          passCount;
   int          failCount;
   logic [31:0] lcgState = 32'h28de4b4a;
   logic        pending;
   int          delayLeft;
   logic        prevReq;
   memReq_t     prevMemReq;

   rvCore u_rvCore (.*);

   initial clk = 1'b0;
   always #5 clk = ~clk;

   function automatic word_t nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   function automatic word_t encR(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
      return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), `OPC_OP};
   endfunction

   function automatic word_t encI(logic [6:0] opc, logic [2:0] f3, int rd, int rs1, int imm);
      return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
   endfunction

   function automatic word_t encS(int rs2, int rs1, int imm);
      logic [11:0] i12;
      i12 = 12'(imm);
      return {i12[11:5], 5'(rs2), 5'(rs1), `F3_SW, i12[4:0], `OPC_STORE};
   endfunction

   function automatic word_t encU(int rd, logic [19:0] imm20);
      return {imm20, 5'(rd), `OPC_LUI};
   endfunction

   function automatic void emit(word_t w);
      mem[progLen] = w;
      progLen++;
   endfunction

   function automatic void clearMemory();
      for (int a = 0; a < memWords; a++) begin
         mem[a] = nextRand();
      end
      progLen = 0;
   endfunction

   // ISA model of the program in mem up to the halt word
   function automatic void runReference();
      word_t      x [32];
      word_t      ins;
      word_t      immI;
      word_t      immS;
      word_t      a;
      word_t      b;
      word_t      res;
      word_t      ea;
      logic [2:0] f3;
      logic [6:0] f7;
      logic       wr;
      for (int i = 0; i < 32; i++) begin
         x[i] = '0;
      end
      for (int i = 0; i < memWords; i++) begin
         expMem[i] = mem[i];
      end
      expLog.delete();
      haltPc = -1;
      for (int pc = 0; pc < memWords && haltPc < 0; pc++) begin
         ins  = expMem[pc];
         f3   = ins[14:12];
         f7   = ins[31:25];
         a    = x[ins[19:15]];
         b    = x[ins[24:20]];
         immI = {{20{ins[31]}}, ins[31:20]};
         immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
         wr   = 1'b1;
         res  = '0;
         case (ins[6:0])
            `OPC_LUI: res = {ins[31:12], 12'h000};
            `OPC_OP: begin
               if (f3 == `F3_ADD && f7 == 7'b0) res = a + b;
               else if (f3 == `F3_ADD && f7 == `F7_SUB) res = a - b;
               else if (f3 == `F3_SLL && f7 == 7'b0) res = a << b[4:0];
               else wr = 1'b0;
            end
            `OPC_OPIMM: begin
               case (f3)
                  `F3_ADD: res = a + immI;
                  `F3_AND: res = a & immI;
                  `F3_OR:  res = a | immI;
                  `F3_SLL: res = a << immI[4:0];
                  default: wr = 1'b0;
               endcase
            end
            `OPC_LOAD: begin
               ea  = a + immI;
               res = expMem[ea[7:0]];
               wr  = (f3 == `F3_LW);
            end
            `OPC_STORE: begin
               wr = 1'b0;
               if (f3 == `F3_SW) begin
                  ea = a + immS;
                  expMem[ea[7:0]] = b;
                  expLog.push_back('{addr: ea, data: b});
               end
            end
            `OPC_HALT: begin
               haltPc = pc;
               wr     = 1'b0;
            end
            default: wr = 1'b0;   // No-op
         endcase
         if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = res;
      end
   endfunction

   function automatic void genRandomProgram(int n, bit memHeavy);
      int kind;
      int rd;
      int rs1;
      int rs2;
      int imm;
      int dAddr;
      for (int i = 0; i < n; i++) begin
         kind  = memHeavy ? 6 + int'(nextRand() % 4) : int'(nextRand() % 10);
         rd    = int'(nextRand() % 32);
         rs1   = int'(nextRand() % 32);
         rs2   = int'(nextRand() % 32);
         imm   = int'(nextRand() % 4096);
         dAddr = dataBase + int'(nextRand() % 128);
         case (kind)
            0: emit(encU(rd, 20'(nextRand())));
            1: emit(encR(7'b0, rs2, rs1, `F3_ADD, rd));
            2: emit(encR(`F7_SUB, rs2, rs1, `F3_ADD, rd));
            3: emit(encR(7'b0, rs2, rs1, `F3_SLL, rd));
            4: emit(encI(`OPC_OPIMM, `F3_ADD, rd, rs1, imm));
            5: emit(encI(`OPC_OPIMM, `F3_AND, rd, rs1, imm));
            6: emit(encI(`OPC_OPIMM, `F3_OR, rd, rs1, imm));
            7: emit(encI(`OPC_OPIMM, `F3_SLL, rd, rs1, imm % 32));
            8: emit(encI(`OPC_LOAD, `F3_LW, rd, 0, dAddr));
            default: emit(encS(rs2, 0, dAddr));
         endcase
      end
      emit(word_t'(`OPC_HALT));
   endfunction

   task automatic checkStore(word_t addr, word_t data);
      storeRec_t want;
      assert (storeIdx < expLog.size()) else begin
         $display("Store %0d to address %0d at %t was not expected", storeIdx, addr, $time);
         testErrors++;
      end
      if (storeIdx < expLog.size()) begin
         want = expLog[storeIdx];
         assert (addr == want.addr && data == want.data) else begin
            $display("Mismatch at %t: store %0d wrote %h to address %0d, expected %h to %0d",
                     $time, storeIdx, data, addr, want.data, want.addr);
            testErrors++;
         end
      end
      storeIdx++;
   endtask

   // Bus memory with random delays on both ack edges
   always @(negedge clk) begin
      if (!rstn) begin
         ack     <= 1'b0;
         pending = 1'b0;
      end else if (req && !ack) begin
         if (!pending) begin
            pending   = 1'b1;
            delayLeft = int'(nextRand() % 4);
         end
         if (delayLeft == 0) begin
            pending = 1'b0;
            ack <= 1'b1;
            if (memReq.we) begin
               mem[memReq.addr[7:0]] = memReq.wdata;
               checkStore(memReq.addr, memReq.wdata);
            end else begin
               rdata <= mem[memReq.addr[7:0]];
            end
         end else begin
            delayLeft--;
         end
      end else if (!req && ack) begin
         if (!pending) begin
            pending   = 1'b1;
            delayLeft = int'(nextRand() % 4);
         end
         if (delayLeft == 0) begin
            pending = 1'b0;
            ack <= 1'b0;
         end else begin
            delayLeft--;
         end
      end
   end

   // Handshake monitor sees ack as held over the last rising edge
   always @(negedge clk) begin
      if (rstn) begin
         assert (!(prevReq && req) || memReq == prevMemReq) else begin
            $display("Request payload changed while req was high at %t", $time);
            testErrors++;
         end
         if (req && !prevReq) begin
            assert (!ack) else begin
               $display("Request raised while ack was still high at %t", $time);
               testErrors++;
            end
            assert (memReq.we || memReq.addr >= dataBase || memReq.addr <= haltPc) else begin
               $display("Fetch from address %0d past the halt word at %t", memReq.addr, $time);
               testErrors++;
            end
         end
      end
      prevReq    = req;
      prevMemReq = memReq;
   end

   task automatic runProgram(string name, int num);
      testErrors = 0;
      storeIdx   = 0;
      runReference();
      rstn  = 1'b0;
      start = 1'b0;
      repeat (8) @(negedge clk);
      rstn = 1'b1;
      repeat (4) begin
         @(negedge clk);
         assert (halted && !req) else begin
            $display("Core left halt or raised req before start at %t", $time);
            testErrors++;
         end
      end
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      while (!req) @(negedge clk);
      assert (memReq.addr == `RESET_PC && !memReq.we) else begin
         $display("Mismatch at %t: first request address %0d we %b, expected a read of 0",
                  $time, memReq.addr, memReq.we);
         testErrors++;
      end
      while (!halted) @(negedge clk);
      repeat (10) begin
         @(negedge clk);
         assert (!req) else begin
            $display("Request raised after the core halted at %t", $time);
            testErrors++;
         end
      end
      assert (storeIdx == expLog.size()) else begin
         $display("Core made %0d stores where %0d were expected", storeIdx, expLog.size());
         testErrors++;
      end
      for (int a = 0; a < memWords; a++) begin
         assert (mem[a] == expMem[a]) else begin
            $display("Mismatch at %t: mem[%0d] is %h, expected %h", $time, a, mem[a], expMem[a]);
            testErrors++;
         end
      end
      if (testErrors == 0) begin
         passCount++;
         $display("Test %0d %s: passed", num, name);
      end else begin
         failCount++;
         $display("Test %0d %s: failed with %0d errors", num, name, testErrors);
      end
   endtask

   initial begin
      #(200 * maxProg * numTests * 4 * 10);
      $display("Timeout: the core never halted within the time allowed for all tests");
      $display("STATUS: FAIL");
      $finish;
   end

   initial begin
      rstn      = 1'b0;
      start     = 1'b0;
      ack       = 1'b0;
      rdata     = '0;
      haltPc    = -1;
      passCount = 0;
      failCount = 0;

      clearMemory();
      emit(encI(`OPC_OPIMM, `F3_ADD, 1, 0, 5));
      emit(encS(1, 0, 200));
      emit(word_t'(`OPC_HALT));
      runProgram("startup and first fetch", 1);

      clearMemory();
      emit(encU(1, 20'habcde));
      emit(encI(`OPC_OPIMM, `F3_ADD, 2, 1, -1));
      emit(encI(`OPC_OPIMM, `F3_OR, 3, 0, -256));
      emit(encI(`OPC_OPIMM, `F3_AND, 4, 2, 12'h7f0));
      emit(encI(`OPC_OPIMM, `F3_SLL, 5, 3, 4));
      emit(encI(`OPC_OPIMM, `F3_ADD, 0, 0, 77));   // x0 must stay zero
      emit(encU(0, 20'h12345));
      emit(encI(`OPC_OPIMM, `F3_ADD, 6, 0, -2048));
      for (int r = 0; r <= 6; r++) begin
         emit(encS(r, 0, 130 + r));
      end
      emit(word_t'(`OPC_HALT));
      runProgram("immediate ops", 2);

      clearMemory();
      for (int i = 0; i < 6; i++) begin
         emit(encU(1, 20'(nextRand())));
         emit(encI(`OPC_OPIMM, `F3_ADD, 1, 1, int'(nextRand() % 4096)));
         emit(encU(2, 20'(nextRand())));
         emit(encI(`OPC_OPIMM, `F3_ADD, 2, 2, int'(nextRand() % 4096)));
         emit(encR(7'b0, 2, 1, `F3_ADD, 3));
         emit(encR(`F7_SUB, 2, 1, `F3_ADD, 4));
         emit(encR(7'b0, 2, 1, `F3_SLL, 5));
         emit(encS(3, 0, dataBase + 3 * i));
         emit(encS(4, 0, dataBase + 3 * i + 1));
         emit(encS(5, 0, dataBase + 3 * i + 2));
      end
      emit(word_t'(`OPC_HALT));
      runProgram("register ops", 3);

      clearMemory();
      for (int a = 200; a < 204; a++) begin
         mem[a] = nextRand();
      end
      emit(encI(`OPC_LOAD, `F3_LW, 1, 0, 200));
      emit(encI(`OPC_LOAD, `F3_LW, 2, 0, 201));
      emit(encR(7'b0, 2, 1, `F3_ADD, 3));
      emit(encR(`F7_SUB, 1, 3, `F3_ADD, 4));
      emit(encI(`OPC_LOAD, `F3_LW, 5, 0, 202));
      emit(encR(7'b0, 2, 5, `F3_SLL, 6));
      emit(encI(`OPC_OPIMM, `F3_ADD, 7, 0, 100));
      emit(encI(`OPC_LOAD, `F3_LW, 8, 7, 103));
      emit(encI(`OPC_OPIMM, `F3_ADD, 9, 8, -3));
      emit(encI(`OPC_OPIMM, `F3_ADD, 10, 0, 210));
      emit(encI(`OPC_LOAD, `F3_LW, 11, 10, -7));   // Negative offset to 203
      emit(encS(3, 0, 150));
      emit(encI(`OPC_LOAD, `F3_LW, 12, 0, 150));
      for (int r = 3; r <= 12; r++) begin
         emit(encS(r, 0, 160 + r));
      end
      emit(word_t'(`OPC_HALT));
      runProgram("loads with dependents", 4);

      clearMemory();
      genRandomProgram(40, 1'b1);
      runProgram("bus handshake stress", 5);

      for (int t = 6; t <= numTests; t++) begin
         clearMemory();
         genRandomProgram(maxProg - 4, 1'b0);
         runProgram("random program", t);
      end

      $display("Tests passed: %0d, failed: %0d", passCount, failCount);
      if (failCount == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* hdl/rvCore.sv */
`timescale 1ns/1ps
`default_nettype none

module rvCore (
   input  wire logic              clk,
   input  wire logic              rstn,
   input  wire logic              start,
   output logic                   halted,
   output logic                   req,
   input  wire logic              ack,
   output rvCorePkg::memReq_t     memReq,
   input  wire rvCorePkg::word_t  rdata
);

   import rvCorePkg::*;

   word_t         instr;
   decodedInstr_t dec;
   regIdx_t       rs1Idx;
   regIdx_t       rs2Idx;
   word_t         rsData1;
   word_t         rsData2;
   word_t         aluResult;
   regWrite_t     regWrite;

   assign rs1Idx = dec.rs1;
   assign rs2Idx = dec.rs2;

   coreControl u_coreControl (
      .clk       (clk),
      .rstn      (rstn),
      .start     (start),
      .halted    (halted),
      .req       (req),
      .ack       (ack),
      .memReq    (memReq),
      .rdata     (rdata),
      .instr     (instr),
      .dec       (dec),
      .aluResult (aluResult),
      .rsData2   (rsData2),
      .regWrite  (regWrite)
   );

   instrDecoder u_instrDecoder (
      .instr (instr),
      .dec   (dec)
   );

   regFile u_regFile (
      .clk      (clk),
      .rstn     (rstn),
      .rs1      (rs1Idx),
      .rs2      (rs2Idx),
      .rsData1  (rsData1),
      .rsData2  (rsData2),
      .regWrite (regWrite)
   );

   execUnit u_execUnit (
      .dec       (dec),
      .rsData1   (rsData1),
      .rsData2   (rsData2),
      .aluResult (aluResult)
   );

endmodule

`default_nettype wire

/* hdl/execUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module execUnit (
   input  wire rvCorePkg::decodedInstr_t dec,
   input  wire rvCorePkg::word_t         rsData1,
   input  wire rvCorePkg::word_t         rsData2,
   output rvCorePkg::word_t              aluResult
);

   import rvCorePkg::*;

   word_t opB;

   assign opB = dec.useImm ? dec.imm : rsData2;

   // Loads and stores arrive as ALU_ADD with imm, giving the word address
   always_comb begin
      case (dec.aluOp)
         ALU_ADD: begin
            aluResult = rsData1 + opB;
         end
         ALU_SUB: begin
            aluResult = rsData1 - opB;
         end
         ALU_SLL: begin
            aluResult = rsData1 << opB[4:0];   // Low 5 bits only
         end
         ALU_OR: begin
            aluResult = rsData1 | opB;
         end
         ALU_AND: begin
            aluResult = rsData1 & opB;
         end
         ALU_PASSB: begin
            aluResult = opB;   // LUI
         end
         default: begin
            aluResult = rsData1 + opB;
         end
      endcase
   end

endmodule

`default_nettype wire

/* hdl/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_macros.svh"

module regFile (
   input  wire logic                 clk,
   input  wire logic                 rstn,
   input  wire rvCorePkg::regIdx_t   rs1,
   input  wire rvCorePkg::regIdx_t   rs2,
   output rvCorePkg::word_t          rsData1,
   output rvCorePkg::word_t          rsData2,
   input  wire rvCorePkg::regWrite_t regWrite
);

   import rvCorePkg::*;

   word_t regs [`REG_COUNT];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (regWrite.en && regWrite.idx != '0) begin   // x0 stays zero
         regs[regWrite.idx] <= regWrite.data;
      end
   end

   assign rsData1 = regs[rs1];
   assign rsData2 = regs[rs2];

endmodule

`default_nettype wire

/* hdl/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_macros.svh"

module instrDecoder (
   input  wire rvCorePkg::word_t    instr,
   output rvCorePkg::decodedInstr_t dec
);

   import rvCorePkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   word_t      immI;
   word_t      immS;
   word_t      immU;

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   assign immI = {{20{instr[31]}}, instr[31:20]};
   assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign immU = {instr[31:12], 12'h000};

   always_comb begin
      dec.kind     = KIND_NOP;
      dec.aluOp    = ALU_ADD;
      dec.useImm   = 1'b0;
      dec.writesRd = 1'b0;
      dec.rd       = instr[11:7];
      dec.rs1      = instr[19:15];
      dec.rs2      = instr[24:20];
      dec.imm      = immI;

      case (opcode)
         `OPC_LUI: begin
            dec.kind     = KIND_ALU;
            dec.aluOp    = ALU_PASSB;
            dec.useImm   = 1'b1;
            dec.writesRd = 1'b1;
            dec.imm      = immU;
         end
         `OPC_OP: begin
            dec.kind     = KIND_ALU;
            dec.writesRd = 1'b1;
            if (funct3 == `F3_ADD && funct7 == `F7_SUB) begin
               dec.aluOp = ALU_SUB;
            end else if (funct3 == `F3_ADD && funct7 == 7'b0) begin
               dec.aluOp = ALU_ADD;
            end else if (funct3 == `F3_SLL && funct7 == 7'b0) begin
               dec.aluOp = ALU_SLL;
            end else begin
               dec.kind     = KIND_NOP;
               dec.writesRd = 1'b0;
            end
         end
         `OPC_OPIMM: begin
            dec.kind     = KIND_ALU;
            dec.useImm   = 1'b1;
            dec.writesRd = 1'b1;
            case (funct3)
               `F3_ADD: dec.aluOp = ALU_ADD;
               `F3_AND: dec.aluOp = ALU_AND;
               `F3_OR:  dec.aluOp = ALU_OR;
               `F3_SLL: dec.aluOp = ALU_SLL;   // shamt sits in imm[4:0]
               default: begin
                  dec.kind     = KIND_NOP;
                  dec.writesRd = 1'b0;
               end
            endcase
         end
         `OPC_LOAD: begin
            if (funct3 == `F3_LW) begin
               dec.kind     = KIND_LOAD;
               dec.useImm   = 1'b1;
               dec.writesRd = 1'b1;
            end
         end
         `OPC_STORE: begin
            if (funct3 == `F3_SW) begin
               dec.kind   = KIND_STORE;
               dec.useImm = 1'b1;
               dec.imm    = immS;
            end
         end
         `OPC_HALT: dec.kind = KIND_HALT;
         default:   dec.kind = KIND_NOP;
      endcase
   end

endmodule

`default_nettype wire

/* hdl/coreControl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_macros.svh"

module coreControl (
   input  wire logic                     clk,
   input  wire logic                     rstn,
   input  wire logic                     start,
   output logic                          halted,
   output logic                          req,
   input  wire logic                     ack,
   output rvCorePkg::memReq_t            memReq,
   input  wire rvCorePkg::word_t         rdata,
   output rvCorePkg::word_t              instr,
   input  wire rvCorePkg::decodedInstr_t dec,
   input  wire rvCorePkg::word_t         aluResult,
   input  wire rvCorePkg::word_t         rsData2,
   output rvCorePkg::regWrite_t          regWrite
);

   import rvCorePkg::*;

   coreState_t state;
   word_t      pc;
   word_t      loadData;
   logic       ackSeen;
   logic       busIdle;
   logic       memOp;
   logic       execDone;
   logic       issueFetch;
   logic       issueMem;

   assign ackSeen  = req && ack;
   assign busIdle  = !req && !ack;   // Previous handshake fully closed
   assign memOp    = (dec.kind == KIND_LOAD) || (dec.kind == KIND_STORE);
   assign execDone = (dec.kind == KIND_ALU) || (dec.kind == KIND_NOP);
   assign halted   = (state == ST_HALT);

   // New request only once ack has been seen low
   assign issueFetch = busIdle && ((state == ST_HALT && start) ||
                                   state == ST_FETCH ||
                                   state == ST_WB ||
                                   (state == ST_EXEC && execDone));
   assign issueMem   = busIdle && (state == ST_MEM || (state == ST_EXEC && memOp));

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= ST_HALT;
         pc    <= `RESET_PC;
         req   <= 1'b0;
      end else begin
         if (issueFetch || issueMem) begin
            req <= 1'b1;
         end else if (ackSeen) begin
            req <= 1'b0;
         end

         case (state)
            ST_HALT: begin
               if (start) begin
                  state <= ST_FETCH;
               end
            end
            ST_FETCH: begin
               if (ackSeen) begin
                  state <= ST_EXEC;
                  pc    <= pc + word_t'(1);   // Word addressed
               end
            end
            ST_EXEC: begin
               case (dec.kind)
                  KIND_LOAD, KIND_STORE: state <= ST_MEM;
                  KIND_HALT:             state <= ST_HALT;
                  default:               state <= ST_FETCH;
               endcase
            end
            ST_MEM: begin
               if (ackSeen) begin
                  state <= (dec.kind == KIND_LOAD) ? ST_WB : ST_FETCH;
               end
            end
            ST_WB:   state <= ST_FETCH;
            default: state <= ST_HALT;
         endcase
      end
   end

   // Instruction register, load data and bus payload
   always_ff @(posedge clk) begin
      if (state == ST_FETCH && ackSeen) begin
         instr <= rdata;
      end
      if (state == ST_MEM && ackSeen) begin
         loadData <= rdata;
      end
      if (issueFetch) begin
         memReq <= '{addr: pc, wdata: '0, we: 1'b0};
      end else if (state == ST_EXEC && memOp) begin
         // Held until the data phase completes
         memReq <= '{addr: aluResult, wdata: rsData2, we: (dec.kind == KIND_STORE)};
      end
   end

   always_comb begin
      regWrite.en   = dec.writesRd &&
                      ((state == ST_EXEC && dec.kind == KIND_ALU) || state == ST_WB);
      regWrite.idx  = dec.rd;
      regWrite.data = (state == ST_WB) ? loadData : aluResult;
   end

endmodule

`default_nettype wire

/* hdl/rvCorePkg.sv */
`default_nettype none

`include "rvCore_macros.svh"

package rvCorePkg;

   typedef logic [`XLEN-1:0]   word_t;
   typedef logic [`REG_AW-1:0] regIdx_t;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_OR, ALU_AND, ALU_PASSB
   } aluOp_t;

   typedef enum logic [2:0] {
      KIND_ALU, KIND_LOAD, KIND_STORE, KIND_HALT, KIND_NOP
   } instrKind_t;

   typedef struct packed {
      instrKind_t kind;
      aluOp_t     aluOp;
      logic       useImm;   // Operand B from imm instead of rs2
      logic       writesRd;
      regIdx_t    rd;
      regIdx_t    rs1;
      regIdx_t    rs2;
      word_t      imm;
   } decodedInstr_t;

   typedef struct packed {
      word_t addr;
      word_t wdata;
      logic  we;
   } memReq_t;

   typedef struct packed {
      logic    en;
      regIdx_t idx;
      word_t   data;
   } regWrite_t;

   typedef enum logic [2:0] {
      ST_HALT, ST_FETCH, ST_EXEC, ST_MEM, ST_WB
   } coreState_t;

endpackage

`default_nettype wire

/* hdl/rvCore_macros.svh */
`ifndef RVCORE_MACROS_SVH
`define RVCORE_MACROS_SVH

`define XLEN       32
`define REG_COUNT  32
`define REG_AW     5

// Major opcodes
`define OPC_LUI    7'b0110111
`define OPC_OP     7'b0110011
`define OPC_OPIMM  7'b0010011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_HALT   7'b1111111

`define F3_ADD     3'b000
`define F3_SLL     3'b001
`define F3_OR      3'b110
`define F3_AND     3'b111
`define F3_LW      3'b010
`define F3_SW      3'b010
`define F7_SUB     7'b0100000

`define RESET_PC   32'h0000_0000

`endif
